// ==== logic/rs_pkg.sv ====
package rs_pkg;

    localparam int XLEN    = 32;  // operand / data width
    localparam int PC_LEN  = 32;
    localparam int OFF_LEN = 16;  // immediate offset

    // add is the idle value on empty lanes
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT
    } alu_func_t;

endpackage

// ==== logic/rs_entry.sv ====
`timescale 1ns/100ps

module rs_entry #(
    parameter int WAYS     = 3,
    parameter int PRF_SIZE = 64,
    parameter int ROB_SIZE = 16,
    localparam int TAG_W   = $clog2(PRF_SIZE),
    localparam int ROB_W   = $clog2(ROB_SIZE)
) (
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              load,
    input  logic                              dealloc,  // entry issued this cycle
    input  logic [rs_pkg::XLEN-1:0]           load_opa, load_opb,
    input  logic                              load_opa_ready, load_opb_ready,
    input  logic [TAG_W-1:0]                  load_dest_tag,
    input  logic [ROB_W-1:0]                  load_rob_idx,
    input  logic [rs_pkg::PC_LEN-1:0]         load_pc,
    input  logic [rs_pkg::OFF_LEN-1:0]        load_offset,
    input  rs_pkg::alu_func_t                 load_alu_func,
    input  logic                              load_rd_mem, load_wr_mem,
    input  logic [WAYS-1:0]                   cdb_valid,
    input  logic [WAYS-1:0][TAG_W-1:0]        cdb_tag,
    input  logic [WAYS-1:0][rs_pkg::XLEN-1:0] cdb_data,
    output logic                              free,
    output logic                              ready,
    output logic [rs_pkg::XLEN-1:0]           opa, opb,
    output logic [TAG_W-1:0]                  dest_tag,
    output logic [ROB_W-1:0]                  rob_idx,
    output logic [rs_pkg::PC_LEN-1:0]         pc,
    output logic [rs_pkg::OFF_LEN-1:0]        offset,
    output rs_pkg::alu_func_t                 alu_func,
    output logic                              rd_mem, wr_mem
);

    logic                    occupied;
    logic                    opa_rdy, opb_rdy;
    logic                    opa_rdy_next, opb_rdy_next;
    logic [rs_pkg::XLEN-1:0] opa_next, opb_next;

    assign free  = ~occupied;
    assign ready = occupied & opa_rdy & opb_rdy;

    // a waiting operand holds its tag in the low bits
    always_comb begin
        opa_next     = opa;
        opb_next     = opb;
        opa_rdy_next = opa_rdy;
        opb_rdy_next = opb_rdy;
        for (int i = 0; i < WAYS; i++) begin
            if (occupied && !opa_rdy && cdb_valid[i] && cdb_tag[i] == opa[TAG_W-1:0]) begin
                opa_next     = cdb_data[i];
                opa_rdy_next = 1'b1;
            end
            if (occupied && !opb_rdy && cdb_valid[i] && cdb_tag[i] == opb[TAG_W-1:0]) begin
                opb_next     = cdb_data[i];
                opb_rdy_next = 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            occupied <= 1'b0;
            opa_rdy  <= 1'b0;
            opb_rdy  <= 1'b0;
        end else if (load) begin
            occupied <= 1'b1;
            opa_rdy  <= load_opa_ready;
            opb_rdy  <= load_opb_ready;
        end else begin
            occupied <= occupied & ~dealloc;
            opa_rdy  <= opa_rdy_next;
            opb_rdy  <= opb_rdy_next;
        end
    end

    always_ff @(posedge clock) begin
        if (load) begin
            opa      <= load_opa;
            opb      <= load_opb;
            dest_tag <= load_dest_tag;
            rob_idx  <= load_rob_idx;
            pc       <= load_pc;
            offset   <= load_offset;
            alu_func <= load_alu_func;
            rd_mem   <= load_rd_mem;
            wr_mem   <= load_wr_mem;
        end else begin
            opa <= opa_next;
            opb <= opb_next;
        end
    end

    // allocator only targets free entries
    a_load_free: assert property (@(posedge clock) disable iff (reset) load |-> !occupied);
    // selector only frees entries it saw ready
    a_dealloc_ready: assert property (@(posedge clock) disable iff (reset) dealloc |-> ready);

endmodule

// ==== logic/rs_operand_bypass.sv ====
`timescale 1ns/100ps

module rs_operand_bypass #(
    parameter int WAYS     = 3,
    parameter int PRF_SIZE = 64,
    localparam int TAG_W   = $clog2(PRF_SIZE)
) (
    input  logic [WAYS-1:0][rs_pkg::XLEN-1:0] opa, opb,
    input  logic [WAYS-1:0]                   opa_ready, opb_ready,
    input  logic [WAYS-1:0]                   cdb_valid,
    input  logic [WAYS-1:0][TAG_W-1:0]        cdb_tag,
    input  logic [WAYS-1:0][rs_pkg::XLEN-1:0] cdb_data,
    output logic [WAYS-1:0][rs_pkg::XLEN-1:0] opa_out, opb_out,
    output logic [WAYS-1:0]                   opa_ready_out, opb_ready_out
);

    // same-cycle broadcast would otherwise be missed by the entry
    always_comb begin
        opa_out       = opa;
        opb_out       = opb;
        opa_ready_out = opa_ready;
        opb_ready_out = opb_ready;
        for (int k = 0; k < WAYS; k++) begin
            for (int j = 0; j < WAYS; j++) begin
                if (!opa_ready[k] && cdb_valid[j] && cdb_tag[j] == opa[k][TAG_W-1:0]) begin
                    opa_out[k]       = cdb_data[j];
                    opa_ready_out[k] = 1'b1;
                end
                if (!opb_ready[k] && cdb_valid[j] && cdb_tag[j] == opb[k][TAG_W-1:0]) begin
                    opb_out[k]       = cdb_data[j];
                    opb_ready_out[k] = 1'b1;
                end
            end
        end
    end

endmodule

// ==== logic/rs_alloc.sv ====
`timescale 1ns/100ps

module rs_alloc #(
    parameter int WAYS     = 3,
    parameter int ENTRIES  = 16,
    parameter int PRF_SIZE = 64,
    parameter int ROB_SIZE = 16,
    localparam int TAG_W   = $clog2(PRF_SIZE),
    localparam int ROB_W   = $clog2(ROB_SIZE),
    localparam int CNT_W   = $clog2(ENTRIES) + 1
) (
    input  logic [WAYS-1:0]                         dispatch_valid,
    input  logic [WAYS-1:0][rs_pkg::XLEN-1:0]       opa, opb,
    input  logic [WAYS-1:0]                         opa_ready, opb_ready,
    input  logic [WAYS-1:0][TAG_W-1:0]              dest_tag,
    input  logic [WAYS-1:0][ROB_W-1:0]              rob_idx,
    input  logic [WAYS-1:0][rs_pkg::PC_LEN-1:0]     pc,
    input  logic [WAYS-1:0][rs_pkg::OFF_LEN-1:0]    offset,
    input  rs_pkg::alu_func_t [WAYS-1:0]            alu_func,
    input  logic [WAYS-1:0]                         rd_mem, wr_mem,
    input  logic [ENTRIES-1:0]                      entry_free,
    output logic [ENTRIES-1:0]                      entry_load,
    output logic [ENTRIES-1:0][rs_pkg::XLEN-1:0]    load_opa, load_opb,
    output logic [ENTRIES-1:0]                      load_opa_ready, load_opb_ready,
    output logic [ENTRIES-1:0][TAG_W-1:0]           load_dest_tag,
    output logic [ENTRIES-1:0][ROB_W-1:0]           load_rob_idx,
    output logic [ENTRIES-1:0][rs_pkg::PC_LEN-1:0]  load_pc,
    output logic [ENTRIES-1:0][rs_pkg::OFF_LEN-1:0] load_offset,
    output rs_pkg::alu_func_t [ENTRIES-1:0]         load_alu_func,
    output logic [ENTRIES-1:0]                      load_rd_mem, load_wr_mem,
    output logic [CNT_W-1:0]                        alloc_count
);

    // lane k lands in the k-th free entry
    always_comb begin
        int lane;
        lane        = 0;
        alloc_count = '0;
        for (int e = 0; e < ENTRIES; e++) begin
            entry_load[e]     = 1'b0;
            load_opa[e]       = '0;
            load_opb[e]       = '0;
            load_opa_ready[e] = 1'b0;
            load_opb_ready[e] = 1'b0;
            load_dest_tag[e]  = '0;
            load_rob_idx[e]   = '0;
            load_pc[e]        = '0;
            load_offset[e]    = '0;
            load_alu_func[e]  = rs_pkg::ALU_ADD;
            load_rd_mem[e]    = 1'b0;
            load_wr_mem[e]    = 1'b0;
            if (entry_free[e] && lane < WAYS) begin
                if (dispatch_valid[lane]) begin
                    entry_load[e]     = 1'b1;
                    load_opa[e]       = opa[lane];
                    load_opb[e]       = opb[lane];
                    load_opa_ready[e] = opa_ready[lane];
                    load_opb_ready[e] = opb_ready[lane];
                    load_dest_tag[e]  = dest_tag[lane];
                    load_rob_idx[e]   = rob_idx[lane];
                    load_pc[e]        = pc[lane];
                    load_offset[e]    = offset[lane];
                    load_alu_func[e]  = alu_func[lane];
                    load_rd_mem[e]    = rd_mem[lane];
                    load_wr_mem[e]    = wr_mem[lane];
                    alloc_count       = alloc_count + 1'b1;
                end
                lane++;
            end
        end
    end

endmodule

// ==== logic/rs_issue_select.sv ====
`timescale 1ns/100ps

module rs_issue_select #(
    parameter int WAYS     = 3,
    parameter int ENTRIES  = 16,
    parameter int PRF_SIZE = 64,
    parameter int ROB_SIZE = 16,
    localparam int TAG_W   = $clog2(PRF_SIZE),
    localparam int ROB_W   = $clog2(ROB_SIZE),
    localparam int CNT_W   = $clog2(ENTRIES) + 1
) (
    input  logic [ENTRIES-1:0]                      entry_ready,
    input  logic [ENTRIES-1:0][rs_pkg::XLEN-1:0]    entry_opa, entry_opb,
    input  logic [ENTRIES-1:0][TAG_W-1:0]           entry_dest_tag,
    input  logic [ENTRIES-1:0][ROB_W-1:0]           entry_rob_idx,
    input  logic [ENTRIES-1:0][rs_pkg::PC_LEN-1:0]  entry_pc,
    input  logic [ENTRIES-1:0][rs_pkg::OFF_LEN-1:0] entry_offset,
    input  rs_pkg::alu_func_t [ENTRIES-1:0]         entry_alu_func,
    input  logic [ENTRIES-1:0]                      entry_rd_mem, entry_wr_mem,
    output logic [ENTRIES-1:0]                      entry_release,
    output logic [WAYS-1:0]                         issue_valid,
    output logic [WAYS-1:0][rs_pkg::XLEN-1:0]       issue_opa, issue_opb,
    output logic [WAYS-1:0][TAG_W-1:0]              issue_dest_tag,
    output logic [WAYS-1:0][ROB_W-1:0]              issue_rob_idx,
    output logic [WAYS-1:0][rs_pkg::PC_LEN-1:0]     issue_pc,
    output logic [WAYS-1:0][rs_pkg::OFF_LEN-1:0]    issue_offset,
    output rs_pkg::alu_func_t [WAYS-1:0]            issue_alu_func,
    output logic [WAYS-1:0]                         issue_rd_mem, issue_wr_mem,
    output logic [CNT_W-1:0]                        issue_count
);

    // lowest ready entries first, packed from lane 0
    always_comb begin
        int lane;
        lane           = 0;
        entry_release  = '0;
        issue_valid    = '0;
        issue_opa      = '0;
        issue_opb      = '0;
        issue_dest_tag = '0;
        issue_rob_idx  = '0;
        issue_pc       = '0;
        issue_offset   = '0;
        issue_rd_mem   = '0;
        issue_wr_mem   = '0;
        for (int k = 0; k < WAYS; k++)
            issue_alu_func[k] = rs_pkg::ALU_ADD;
        for (int e = 0; e < ENTRIES; e++) begin
            if (entry_ready[e] && lane < WAYS) begin
                entry_release[e]     = 1'b1;
                issue_valid[lane]    = 1'b1;
                issue_opa[lane]      = entry_opa[e];
                issue_opb[lane]      = entry_opb[e];
                issue_dest_tag[lane] = entry_dest_tag[e];
                issue_rob_idx[lane]  = entry_rob_idx[e];
                issue_pc[lane]       = entry_pc[e];
                issue_offset[lane]   = entry_offset[e];
                issue_alu_func[lane] = entry_alu_func[e];
                issue_rd_mem[lane]   = entry_rd_mem[e];
                issue_wr_mem[lane]   = entry_wr_mem[e];
                lane++;
            end
        end
        issue_count = CNT_W'(lane);
    end

endmodule

// ==== logic/reservation_station.sv ====
`timescale 1ns/100ps

module reservation_station #(
    parameter int WAYS     = 3,
    parameter int ENTRIES  = 16,
    parameter int PRF_SIZE = 64,
    parameter int ROB_SIZE = 16,
    localparam int TAG_W   = $clog2(PRF_SIZE),
    localparam int ROB_W   = $clog2(ROB_SIZE),
    localparam int CNT_W   = $clog2(ENTRIES) + 1  // holds ENTRIES itself
) (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic [WAYS-1:0]                      cdb_valid,
    input  logic [WAYS-1:0][TAG_W-1:0]           cdb_tag,
    input  logic [WAYS-1:0][rs_pkg::XLEN-1:0]    cdb_data,
    input  logic [WAYS-1:0]                      dispatch_valid,
    input  logic [WAYS-1:0][rs_pkg::XLEN-1:0]    opa, opb,
    input  logic [WAYS-1:0]                      opa_ready, opb_ready,
    input  logic [WAYS-1:0][TAG_W-1:0]           dest_tag,
    input  logic [WAYS-1:0][ROB_W-1:0]           rob_idx,
    input  logic [WAYS-1:0][rs_pkg::PC_LEN-1:0]  pc,
    input  logic [WAYS-1:0][rs_pkg::OFF_LEN-1:0] offset,
    input  rs_pkg::alu_func_t [WAYS-1:0]         alu_func,
    input  logic [WAYS-1:0]                      rd_mem, wr_mem,
    output logic [WAYS-1:0]                      issue_valid,
    output logic [WAYS-1:0][rs_pkg::XLEN-1:0]    issue_opa, issue_opb,
    output logic [WAYS-1:0][TAG_W-1:0]           issue_dest_tag,
    output logic [WAYS-1:0][ROB_W-1:0]           issue_rob_idx,
    output logic [WAYS-1:0][rs_pkg::PC_LEN-1:0]  issue_pc,
    output logic [WAYS-1:0][rs_pkg::OFF_LEN-1:0] issue_offset,
    output rs_pkg::alu_func_t [WAYS-1:0]         issue_alu_func,
    output logic [WAYS-1:0]                      issue_rd_mem, issue_wr_mem,
    output logic [CNT_W-1:0]                     free_count
);

    logic [WAYS-1:0][rs_pkg::XLEN-1:0]       byp_opa, byp_opb;
    logic [WAYS-1:0]                         byp_opa_ready, byp_opb_ready;

    logic [ENTRIES-1:0]                      entry_load;
    logic [ENTRIES-1:0][rs_pkg::XLEN-1:0]    load_opa, load_opb;
    logic [ENTRIES-1:0]                      load_opa_ready, load_opb_ready;
    logic [ENTRIES-1:0][TAG_W-1:0]           load_dest_tag;
    logic [ENTRIES-1:0][ROB_W-1:0]           load_rob_idx;
    logic [ENTRIES-1:0][rs_pkg::PC_LEN-1:0]  load_pc;
    logic [ENTRIES-1:0][rs_pkg::OFF_LEN-1:0] load_offset;
    rs_pkg::alu_func_t [ENTRIES-1:0]         load_alu_func;
    logic [ENTRIES-1:0]                      load_rd_mem, load_wr_mem;

    logic [ENTRIES-1:0]                      entry_free, entry_ready, entry_release;
    logic [ENTRIES-1:0][rs_pkg::XLEN-1:0]    entry_opa, entry_opb;
    logic [ENTRIES-1:0][TAG_W-1:0]           entry_dest_tag;
    logic [ENTRIES-1:0][ROB_W-1:0]           entry_rob_idx;
    logic [ENTRIES-1:0][rs_pkg::PC_LEN-1:0]  entry_pc;
    logic [ENTRIES-1:0][rs_pkg::OFF_LEN-1:0] entry_offset;
    rs_pkg::alu_func_t [ENTRIES-1:0]         entry_alu_func;
    logic [ENTRIES-1:0]                      entry_rd_mem, entry_wr_mem;

    logic [CNT_W-1:0]                        alloc_count, issue_count;

    rs_operand_bypass #(.WAYS(WAYS), .PRF_SIZE(PRF_SIZE)) u_bypass (
        .opa(opa), .opb(opb), .opa_ready(opa_ready), .opb_ready(opb_ready),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
        .opa_out(byp_opa), .opb_out(byp_opb),
        .opa_ready_out(byp_opa_ready), .opb_ready_out(byp_opb_ready)
    );

    rs_alloc #(
        .WAYS(WAYS), .ENTRIES(ENTRIES), .PRF_SIZE(PRF_SIZE), .ROB_SIZE(ROB_SIZE)
    ) u_alloc (
        .dispatch_valid(dispatch_valid),
        .opa(byp_opa), .opb(byp_opb), .opa_ready(byp_opa_ready), .opb_ready(byp_opb_ready),
        .dest_tag(dest_tag), .rob_idx(rob_idx), .pc(pc), .offset(offset),
        .alu_func(alu_func), .rd_mem(rd_mem), .wr_mem(wr_mem),
        .entry_free(entry_free), .entry_load(entry_load),
        .load_opa(load_opa), .load_opb(load_opb),
        .load_opa_ready(load_opa_ready), .load_opb_ready(load_opb_ready),
        .load_dest_tag(load_dest_tag), .load_rob_idx(load_rob_idx),
        .load_pc(load_pc), .load_offset(load_offset), .load_alu_func(load_alu_func),
        .load_rd_mem(load_rd_mem), .load_wr_mem(load_wr_mem),
        .alloc_count(alloc_count)
    );

    for (genvar e = 0; e < ENTRIES; e++) begin : g_entry
        rs_entry #(.WAYS(WAYS), .PRF_SIZE(PRF_SIZE), .ROB_SIZE(ROB_SIZE)) u_entry (
            .clock(clock), .reset(reset),
            .load(entry_load[e]), .dealloc(entry_release[e]),
            .load_opa(load_opa[e]), .load_opb(load_opb[e]),
            .load_opa_ready(load_opa_ready[e]), .load_opb_ready(load_opb_ready[e]),
            .load_dest_tag(load_dest_tag[e]), .load_rob_idx(load_rob_idx[e]),
            .load_pc(load_pc[e]), .load_offset(load_offset[e]),
            .load_alu_func(load_alu_func[e]),
            .load_rd_mem(load_rd_mem[e]), .load_wr_mem(load_wr_mem[e]),
            .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
            .free(entry_free[e]), .ready(entry_ready[e]),
            .opa(entry_opa[e]), .opb(entry_opb[e]),
            .dest_tag(entry_dest_tag[e]), .rob_idx(entry_rob_idx[e]),
            .pc(entry_pc[e]), .offset(entry_offset[e]), .alu_func(entry_alu_func[e]),
            .rd_mem(entry_rd_mem[e]), .wr_mem(entry_wr_mem[e])
        );
    end

    rs_issue_select #(
        .WAYS(WAYS), .ENTRIES(ENTRIES), .PRF_SIZE(PRF_SIZE), .ROB_SIZE(ROB_SIZE)
    ) u_select (
        .entry_ready(entry_ready), .entry_opa(entry_opa), .entry_opb(entry_opb),
        .entry_dest_tag(entry_dest_tag), .entry_rob_idx(entry_rob_idx),
        .entry_pc(entry_pc), .entry_offset(entry_offset), .entry_alu_func(entry_alu_func),
        .entry_rd_mem(entry_rd_mem), .entry_wr_mem(entry_wr_mem),
        .entry_release(entry_release), .issue_valid(issue_valid),
        .issue_opa(issue_opa), .issue_opb(issue_opb),
        .issue_dest_tag(issue_dest_tag), .issue_rob_idx(issue_rob_idx),
        .issue_pc(issue_pc), .issue_offset(issue_offset), .issue_alu_func(issue_alu_func),
        .issue_rd_mem(issue_rd_mem), .issue_wr_mem(issue_wr_mem),
        .issue_count(issue_count)
    );

    always_ff @(posedge clock) begin
        if (reset) begin
            free_count <= CNT_W'(ENTRIES);
        end else begin
            free_count <= free_count - alloc_count + issue_count;
        end
    end

    // dispatch stage must respect the registered free count
    a_dispatch_fits: assert property (@(posedge clock) disable iff (reset)
        $countones(dispatch_valid) <= free_count);

endmodule

// ==== tb/tb_reservation_station.sv ====
`timescale 1ns/100ps

module tb_reservation_station;

    localparam int WAYS       = 3;
    localparam int ENTRIES    = 16;
    localparam int TAG_W      = 6;
    localparam int ROB_W      = 4;
    localparam int CNT_W      = 5;
    localparam int MAX_CYCLES = 400;

    logic                                 clock, reset;
    logic [WAYS-1:0]                      cdb_valid;
    logic [WAYS-1:0][TAG_W-1:0]           cdb_tag;
    logic [WAYS-1:0][rs_pkg::XLEN-1:0]    cdb_data;
    logic [WAYS-1:0]                      dispatch_valid;
    logic [WAYS-1:0][rs_pkg::XLEN-1:0]    opa, opb;
    logic [WAYS-1:0]                      opa_ready, opb_ready;
    logic [WAYS-1:0][TAG_W-1:0]           dest_tag;
    logic [WAYS-1:0][ROB_W-1:0]           rob_idx;
    logic [WAYS-1:0][rs_pkg::PC_LEN-1:0]  pc;
    logic [WAYS-1:0][rs_pkg::OFF_LEN-1:0] offset;
    rs_pkg::alu_func_t [WAYS-1:0]         alu_func;
    logic [WAYS-1:0]                      rd_mem, wr_mem;
    logic [WAYS-1:0]                      issue_valid;
    logic [WAYS-1:0][rs_pkg::XLEN-1:0]    issue_opa, issue_opb;
    logic [WAYS-1:0][TAG_W-1:0]           issue_dest_tag;
    logic [WAYS-1:0][ROB_W-1:0]           issue_rob_idx;
    logic [WAYS-1:0][rs_pkg::PC_LEN-1:0]  issue_pc;
    logic [WAYS-1:0][rs_pkg::OFF_LEN-1:0] issue_offset;
    rs_pkg::alu_func_t [WAYS-1:0]         issue_alu_func;
    logic [WAYS-1:0]                      issue_rd_mem, issue_wr_mem;
    logic [CNT_W-1:0]                     free_count;

    // expected station contents
    bit                 m_busy [ENTRIES];
    bit                 m_rdy_a [ENTRIES];
    bit                 m_rdy_b [ENTRIES];
    logic [31:0]        m_opa [ENTRIES];
    logic [31:0]        m_opb [ENTRIES];
    logic [TAG_W-1:0]   m_dest [ENTRIES];
    logic [ROB_W-1:0]   m_rob [ENTRIES];
    logic [31:0]        m_pc [ENTRIES];
    logic [15:0]        m_off [ENTRIES];
    rs_pkg::alu_func_t  m_func [ENTRIES];
    bit                 m_rd [ENTRIES];
    bit                 m_wr [ENTRIES];
    int                 m_free;
    int                 seed;
    int                 cycle_count;

    reservation_station dut (.*);

    always #2 clock = ~clock;

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("*** FAILED ***");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("[ERROR] time %0t: %s expected %0h, got %0h", $time, name, exp, act);
            $display("*** FAILED ***");
            $fatal(1);
        end
    endtask

    task automatic clear_inputs();
        dispatch_valid = '0;
        opa = '0;
        opb = '0;
        opa_ready = '0;
        opb_ready = '0;
        dest_tag = '0;
        rob_idx = '0;
        pc = '0;
        offset = '0;
        rd_mem = '0;
        wr_mem = '0;
        cdb_valid = '0;
        cdb_tag = '0;
        cdb_data = '0;
        for (int k = 0; k < WAYS; k++)
            alu_func[k] = rs_pkg::ALU_ADD;
    endtask

    // operands hold data when ready and a tag in the low bits otherwise
    task automatic drive_lane(input int k, input logic [31:0] a, input logic [31:0] b,
                              input bit ra, input bit rb);
        int func_sel;
        func_sel = $unsigned($random(seed)) % 9;
        dispatch_valid[k] = 1'b1;
        opa[k] = a;
        opb[k] = b;
        opa_ready[k] = ra;
        opb_ready[k] = rb;
        dest_tag[k] = TAG_W'($random(seed));
        rob_idx[k] = ROB_W'($random(seed));
        pc[k] = $random(seed);
        offset[k] = 16'($random(seed));
        alu_func[k] = rs_pkg::alu_func_t'(func_sel[3:0]);
        rd_mem[k] = 1'($random(seed));
        wr_mem[k] = 1'($random(seed));
    endtask

    task automatic drive_cdb(input int j, input logic [TAG_W-1:0] tag, input logic [31:0] data);
        cdb_valid[j] = 1'b1;
        cdb_tag[j] = tag;
        cdb_data[j] = data;
    endtask

    // a waiting operand takes the data of any matching broadcast
    task automatic capture_operand(input logic [31:0] val, input bit rdy,
                                   output logic [31:0] val_out, output bit rdy_out);
        val_out = val;
        rdy_out = rdy;
        for (int j = 0; j < WAYS; j++) begin
            if (!rdy && cdb_valid[j] && cdb_tag[j] == val[TAG_W-1:0]) begin
                val_out = cdb_data[j];
                rdy_out = 1'b1;
            end
        end
    endtask

    task automatic check_lane(input int lane, input int e);
        check_value($sformatf("issue_valid[%0d]", lane), 1, issue_valid[lane]);
        check_value($sformatf("issue_opa[%0d]", lane), m_opa[e], issue_opa[lane]);
        check_value($sformatf("issue_opb[%0d]", lane), m_opb[e], issue_opb[lane]);
        check_value($sformatf("issue_dest_tag[%0d]", lane), m_dest[e], issue_dest_tag[lane]);
        check_value($sformatf("issue_rob_idx[%0d]", lane), m_rob[e], issue_rob_idx[lane]);
        check_value($sformatf("issue_pc[%0d]", lane), m_pc[e], issue_pc[lane]);
        check_value($sformatf("issue_offset[%0d]", lane), m_off[e], issue_offset[lane]);
        check_value($sformatf("issue_alu_func[%0d]", lane), m_func[e], issue_alu_func[lane]);
        check_value($sformatf("issue_rd_mem[%0d]", lane), m_rd[e], issue_rd_mem[lane]);
        check_value($sformatf("issue_wr_mem[%0d]", lane), m_wr[e], issue_wr_mem[lane]);
    endtask

    // check this cycle's outputs, update the model, move to the next falling edge
    task automatic advance_cycle();
        bit was_free [ENTRIES];
        bit chosen [ENTRIES];
        int lane;
        int k;
        int alloc;
        lane = 0;
        for (int e = 0; e < ENTRIES; e++) begin
            was_free[e] = !m_busy[e];
            chosen[e] = m_busy[e] && m_rdy_a[e] && m_rdy_b[e] && lane < WAYS;
            if (chosen[e]) begin
                check_lane(lane, e);
                lane++;
            end
        end
        for (int l = lane; l < WAYS; l++)
            check_value($sformatf("issue_valid[%0d]", l), 0, issue_valid[l]);
        check_value("free_count", m_free, free_count);
        for (int e = 0; e < ENTRIES; e++) begin
            if (chosen[e]) begin
                m_busy[e] = 1'b0;
            end else if (m_busy[e]) begin
                capture_operand(m_opa[e], m_rdy_a[e], m_opa[e], m_rdy_a[e]);
                capture_operand(m_opb[e], m_rdy_b[e], m_opb[e], m_rdy_b[e]);
            end
        end
        k = 0;
        alloc = 0;
        for (int e = 0; e < ENTRIES; e++) begin
            if (was_free[e] && k < WAYS) begin
                if (dispatch_valid[k]) begin  // lane k into k-th free entry
                    m_busy[e] = 1'b1;
                    capture_operand(opa[k], opa_ready[k], m_opa[e], m_rdy_a[e]);
                    capture_operand(opb[k], opb_ready[k], m_opb[e], m_rdy_b[e]);
                    m_dest[e] = dest_tag[k];
                    m_rob[e] = rob_idx[k];
                    m_pc[e] = pc[k];
                    m_off[e] = offset[k];
                    m_func[e] = alu_func[k];
                    m_rd[e] = rd_mem[k];
                    m_wr[e] = wr_mem[k];
                    alloc++;
                end
                k++;
            end
        end
        m_free = m_free - alloc + lane;
        @(posedge clock);
        @(negedge clock);
        clear_inputs();
    endtask

    task automatic test_reset_state();
        check_value("free_count", ENTRIES, free_count);
        check_value("issue_valid", 0, issue_valid);
    endtask

    task automatic test_ready_group();
        logic [31:0] sent_pc [WAYS];
        for (int k = 0; k < WAYS; k++) begin
            drive_lane(k, $random(seed), $random(seed), 1, 1);
            sent_pc[k] = pc[k];
        end
        advance_cycle();
        check_value("issue_valid", 3'b111, issue_valid);
        for (int k = 0; k < WAYS; k++)
            check_value($sformatf("issue_pc[%0d]", k), sent_pc[k], issue_pc[k]);
        advance_cycle();
        check_value("free_count", ENTRIES, free_count);
    endtask

    task automatic test_cdb_wakeup();
        logic [31:0] data;
        data = $random(seed);
        drive_lane(0, $random(seed), 32'd17, 1, 0);  // opb waits on tag 17
        advance_cycle();
        check_value("issue_valid", 0, issue_valid);
        repeat (3) begin
            drive_cdb(0, 6'd5, $random(seed));
            drive_cdb(2, 6'd40, $random(seed));
            advance_cycle();
            check_value("issue_valid", 0, issue_valid);
        end
        drive_cdb(1, 6'd17, data);
        advance_cycle();
        check_value("issue_valid", 3'b001, issue_valid);
        check_value("issue_opb[0]", data, issue_opb[0]);
        advance_cycle();
    endtask

    task automatic test_dispatch_bypass();
        logic [31:0] data;
        data = $random(seed);
        drive_lane(0, 32'd42, $random(seed), 0, 1);
        drive_cdb(0, 6'd42, data);  // same cycle as dispatch
        advance_cycle();
        check_value("issue_valid", 3'b001, issue_valid);
        check_value("issue_opa[0]", data, issue_opa[0]);
        advance_cycle();
    endtask

    task automatic test_fill_and_drain();
        int n;
        int remaining;
        while (m_free > 0) begin
            n = (m_free < WAYS) ? m_free : WAYS;
            for (int k = 0; k < n; k++)
                drive_lane(k, 32'd50, $random(seed), 0, 1);
            advance_cycle();
        end
        check_value("free_count", 0, free_count);
        check_value("issue_valid", 0, issue_valid);
        drive_cdb(1, 6'd50, $random(seed));  // wakes every entry
        advance_cycle();
        remaining = ENTRIES;
        while (remaining > 0) begin
            n = (remaining < WAYS) ? remaining : WAYS;
            check_value("issued lanes", n, $countones(issue_valid));
            advance_cycle();
            check_value("free_count", ENTRIES - remaining + n, free_count);
            remaining -= n;
        end
    endtask

    task automatic test_dispatch_during_issue();
        for (int k = 0; k < WAYS; k++)
            drive_lane(k, $random(seed), $random(seed), 1, 1);
        advance_cycle();
        drive_lane(0, $random(seed), $random(seed), 1, 1);
        drive_lane(1, $random(seed), $random(seed), 1, 1);
        check_value("issue_valid", 3'b111, issue_valid);
        advance_cycle();
        check_value("free_count", ENTRIES - WAYS - 2 + 3, free_count);
        check_value("issue_valid", 3'b011, issue_valid);
        advance_cycle();
        check_value("free_count", ENTRIES, free_count);
    endtask

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        seed = 85702;
        cycle_count = 0;
        m_free = ENTRIES;
        for (int e = 0; e < ENTRIES; e++)
            m_busy[e] = 1'b0;
        clear_inputs();
        repeat (4) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        test_reset_state();
        test_ready_group();
        test_cdb_wakeup();
        test_dispatch_bypass();
        test_fill_and_drain();
        test_dispatch_during_issue();

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== flist.f ====
logic/rs_pkg.sv
logic/rs_entry.sv
logic/rs_operand_bypass.sv
logic/rs_alloc.sv
logic/rs_issue_select.sv
logic/reservation_station.sv
tb/tb_reservation_station.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the reservation station testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f --top-module tb_reservation_station -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1
